// File: calc.f
+incdir+.
calc_pkg.sv
calc_int_alu.sv
calc_mul_pipe.sv
calc_stage.sv
calc_issue.sv
calc_retire.sv
calc_top.sv
tb_calc.sv

// File: calc_cfg.svh
`ifndef CALC_CFG_SVH
`define CALC_CFG_SVH

// Datapath and register file
`define CALC_XLEN 32
`define CALC_REG_AW 5

// Completion pipe depth, must exceed the multiply latency
`define CALC_STAGES 4

// Unit latencies in completion stages
`define CALC_INT_LAT 1
`define CALC_MUL_LAT 3

// Countdown and retired counter widths
`define CALC_CNT_W 2
`define CALC_CNT_REG_W 16

`endif

// File: calc_int_alu.sv
`timescale 1ns/100ps

module calc_int_alu (
  input  calc_pkg::fu_op_e op_i,
  input  calc_pkg::xlen_t  rs1_i,
  input  calc_pkg::xlen_t  rs2_i,
  output calc_pkg::xlen_t  data_o
);

  logic [4:0] shamt;

  assign shamt = rs2_i[4:0];

  always_comb
  begin
    case (op_i)
      calc_pkg::e_op_add:
        data_o = rs1_i + rs2_i;
      calc_pkg::e_op_sub:
        data_o = rs1_i - rs2_i;
      calc_pkg::e_op_and:
        data_o = rs1_i & rs2_i;
      calc_pkg::e_op_or:
        data_o = rs1_i | rs2_i;
      calc_pkg::e_op_xor:
        data_o = rs1_i ^ rs2_i;
      calc_pkg::e_op_sll:
        data_o = rs1_i << shamt;
      calc_pkg::e_op_srl:
        data_o = rs1_i >> shamt;
      // Signed compare, result zero extended
      calc_pkg::e_op_slt:
        data_o = calc_pkg::xlen_t'($signed(rs1_i) < $signed(rs2_i));
      // Multiplies are not ours
      default:
        data_o = '0;
    endcase
  end

endmodule

// File: calc_issue.sv
`timescale 1ns/100ps
`include "calc_cfg.svh"

module calc_issue (
  input  logic                                        clk_i,
  input  logic                                        rst_n_i,
  input  calc_pkg::dispatch_s                         dispatch_i,
  input  calc_pkg::stage_entry_s [`CALC_STAGES-1:0]   stages_i,
  output calc_pkg::fwd_s                              fwd_o,
  output calc_pkg::stage_entry_s                      entry_o,
  output logic                                        hazard_o
);

  calc_pkg::xlen_t bypass_rs1;
  calc_pkg::xlen_t bypass_rs2;
  calc_pkg::fwd_s  res_n;
  calc_pkg::fwd_s  res_r;
  logic            is_mul;

  // Live producer of a nonzero register
  function automatic logic writes_reg(input calc_pkg::stage_entry_s e,
                                      input calc_pkg::reg_addr_t addr);
    return e.v && !e.poison && e.rd_w_v && (e.rd_addr == addr) && (addr != '0);
  endfunction

  // Youngest completed result wins, so walk from the oldest stage up
  function automatic calc_pkg::xlen_t bypass(
    input calc_pkg::reg_addr_t                      addr,
    input calc_pkg::xlen_t                          value,
    input calc_pkg::stage_entry_s [`CALC_STAGES-1:0] stages
  );
    calc_pkg::xlen_t result;
    result = value;
    for (int i = `CALC_STAGES - 1; i >= 0; i--)
    begin
      if (writes_reg(stages[i], addr) && stages[i].done)
        result = stages[i].data;
    end
    return result;
  endfunction

  function automatic logic pending(
    input calc_pkg::reg_addr_t                      addr,
    input calc_pkg::stage_entry_s [`CALC_STAGES-1:0] stages
  );
    logic hit;
    hit = 1'b0;
    for (int i = 0; i < `CALC_STAGES; i++)
    begin
      if (writes_reg(stages[i], addr) && !stages[i].done)
        hit = 1'b1;
    end
    return hit;
  endfunction

  assign bypass_rs1 = bypass(dispatch_i.rs1_addr, dispatch_i.rs1, stages_i);
  assign bypass_rs2 = bypass(dispatch_i.rs2_addr, dispatch_i.rs2, stages_i);

  assign hazard_o = dispatch_i.v
                    && (pending(dispatch_i.rs1_addr, stages_i)
                        || pending(dispatch_i.rs2_addr, stages_i));

  assign is_mul = (dispatch_i.op == calc_pkg::e_op_mul)
                  || (dispatch_i.op == calc_pkg::e_op_mulhu);

  // Idle cycles present an add so the multiplier stays quiet
  always_comb
  begin
    res_n.op  = dispatch_i.v ? dispatch_i.op : calc_pkg::e_op_add;
    res_n.rs1 = bypass_rs1;
    res_n.rs2 = bypass_rs2;
  end

  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      res_r.op <= calc_pkg::e_op_add;
    end
    else
    begin
      res_r <= res_n;
    end
  end

  assign fwd_o = res_r;

  // Stage 0 entry, loaded in the same edge as the reservation
  always_comb
  begin
    entry_o.v       = dispatch_i.v;
    entry_o.poison  = 1'b0;
    entry_o.pc      = dispatch_i.pc;
    entry_o.unit    = is_mul ? calc_pkg::e_unit_mul : calc_pkg::e_unit_int;
    entry_o.rd_w_v  = dispatch_i.rd_w_v;
    entry_o.rd_addr = dispatch_i.rd_addr;
    entry_o.cnt     = is_mul ? calc_pkg::lat_cnt_t'(`CALC_MUL_LAT)
                             : calc_pkg::lat_cnt_t'(`CALC_INT_LAT);
    entry_o.done    = 1'b0;
    entry_o.data    = '0;
  end

endmodule

// File: calc_mul_pipe.sv
`timescale 1ns/100ps
`include "calc_cfg.svh"

module calc_mul_pipe (
  input  logic            clk_i,
  input  logic            rst_n_i,
  input  calc_pkg::fwd_s  fwd_i,
  output calc_pkg::xlen_t data_o
);

  // Reservation counts as the first stage of latency
  localparam int unsigned LEVELS = `CALC_MUL_LAT - 1;

  logic [2*`CALC_XLEN-1:0] product;
  calc_pkg::xlen_t         prod_sel;
  logic                    is_mul;
  logic [LEVELS-2:0]       v_r;
  calc_pkg::xlen_t         data_r [LEVELS];

  assign is_mul = (fwd_i.op == calc_pkg::e_op_mul) || (fwd_i.op == calc_pkg::e_op_mulhu);

  // Full unsigned product and the selected half
  assign product  = {{`CALC_XLEN{1'b0}}, fwd_i.rs1} * {{`CALC_XLEN{1'b0}}, fwd_i.rs2};
  assign prod_sel = (fwd_i.op == calc_pkg::e_op_mulhu) ? product[2*`CALC_XLEN-1:`CALC_XLEN]
                                                       : product[`CALC_XLEN-1:0];

  // Occupancy of every level that feeds another enables its data load
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      v_r <= '0;
    end
    else
    begin
      v_r[0] <= is_mul;
      for (int i = 1; i < LEVELS - 1; i++)
        v_r[i] <= v_r[i-1];
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (is_mul)
      data_r[0] <= prod_sel;
    for (int i = 1; i < LEVELS; i++)
    begin
      if (v_r[i-1])
        data_r[i] <= data_r[i-1];
    end
  end

  assign data_o = data_r[LEVELS-1];

endmodule

// File: calc_pkg.sv
`include "calc_cfg.svh"

package calc_pkg;

  typedef logic [`CALC_XLEN-1:0] xlen_t;
  typedef logic [`CALC_REG_AW-1:0] reg_addr_t;
  typedef logic [`CALC_XLEN-1:0] pc_t;
  typedef logic [`CALC_CNT_W-1:0] lat_cnt_t;
  typedef logic [`CALC_CNT_REG_W-1:0] instret_t;

  // Operation codes, the last two run on the multiplier
  typedef enum logic [3:0] {
    e_op_add   = 4'h0,
    e_op_sub   = 4'h1,
    e_op_and   = 4'h2,
    e_op_or    = 4'h3,
    e_op_xor   = 4'h4,
    e_op_sll   = 4'h5,
    e_op_srl   = 4'h6,
    e_op_slt   = 4'h7,
    e_op_mul   = 4'h8,
    e_op_mulhu = 4'h9
  } fu_op_e;

  typedef enum logic {
    e_unit_int = 1'b0,
    e_unit_mul = 1'b1
  } fu_unit_e;

  // Decoded instruction with operands already read
  typedef struct packed {
    logic      v;
    pc_t       pc;
    fu_op_e    op;
    logic      rd_w_v;
    reg_addr_t rd_addr;
    reg_addr_t rs1_addr;
    reg_addr_t rs2_addr;
    xlen_t     rs1;
    xlen_t     rs2;
  } dispatch_s;

  // One slot of the completion pipe
  typedef struct packed {
    logic      v;
    logic      poison;
    pc_t       pc;
    fu_unit_e  unit;
    logic      rd_w_v;
    reg_addr_t rd_addr;
    lat_cnt_t  cnt;
    logic      done;
    xlen_t     data;
  } stage_entry_s;

  // Reservation contents seen by both units
  typedef struct packed {
    fu_op_e op;
    xlen_t  rs1;
    xlen_t  rs2;
  } fwd_s;

  typedef struct packed {
    logic v;
    pc_t  pc;
  } commit_s;

  typedef struct packed {
    logic      v;
    reg_addr_t rd_addr;
    xlen_t     data;
  } wb_s;

endpackage

// File: calc_retire.sv
`timescale 1ns/100ps

module calc_retire (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  calc_pkg::stage_entry_s entry_i,
  output calc_pkg::commit_s      commit_o,
  output calc_pkg::wb_s          wb_o,
  output calc_pkg::instret_t     instret_o
);

  calc_pkg::instret_t instret_r;

  // Poisoned entries drop out silently
  assign commit_o.v  = entry_i.v && !entry_i.poison;
  assign commit_o.pc = entry_i.pc;

  // x0 destinations commit without a writeback
  assign wb_o.v       = commit_o.v && entry_i.rd_w_v && (entry_i.rd_addr != '0);
  assign wb_o.rd_addr = entry_i.rd_addr;
  assign wb_o.data    = entry_i.data;

  // Wraps at the counter width
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      instret_r <= '0;
    end
    else if (commit_o.v)
    begin
      instret_r <= instret_r + calc_pkg::instret_t'(1);
    end
  end

  assign instret_o = instret_r;

endmodule

// File: calc_stage.sv
`timescale 1ns/100ps

module calc_stage (
  input  logic                   clk_i,
  input  logic                   rst_n_i,
  input  logic                   flush_i,
  input  calc_pkg::xlen_t        int_data_i,
  input  calc_pkg::xlen_t        mul_data_i,
  input  calc_pkg::stage_entry_s entry_i,
  output calc_pkg::stage_entry_s entry_o
);

  calc_pkg::stage_entry_s entry_r;
  logic                   result_due;

  // Shift in from the previous stage, poisoning on flush
  always_ff @(posedge clk_i)
  begin
    if (!rst_n_i)
    begin
      entry_r.v <= 1'b0;
    end
    else
    begin
      entry_r        <= entry_i;
      entry_r.poison <= entry_i.poison | flush_i;
    end
  end

  // The unit result is on its port during the cycle the count reads one
  assign result_due = entry_r.v && !entry_r.done && (entry_r.cnt == calc_pkg::lat_cnt_t'(1));

  // The next stage registers what we present here,
  // so the captured result lands one stage further down
  always_comb
  begin
    entry_o = entry_r;
    if (result_due)
    begin
      entry_o.done = 1'b1;
      entry_o.cnt  = '0;
      if (entry_r.unit == calc_pkg::e_unit_mul)
        entry_o.data = mul_data_i;
      else
        entry_o.data = int_data_i;
    end
    else if (entry_r.v && !entry_r.done)
    begin
      entry_o.cnt = entry_r.cnt - calc_pkg::lat_cnt_t'(1);
    end
  end

endmodule

// File: calc_top.sv
`timescale 1ns/100ps
`include "calc_cfg.svh"

module calc_top (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  calc_pkg::dispatch_s dispatch_i,
  input  logic                flush_i,
  output logic                hazard_o,
  output calc_pkg::commit_s   commit_o,
  output calc_pkg::wb_s       wb_o,
  output calc_pkg::instret_t  instret_o
);

  // chain[0] is the issue entry, chain[k+1] the output of stage k
  calc_pkg::stage_entry_s [`CALC_STAGES:0] chain;
  calc_pkg::fwd_s                          fwd;
  calc_pkg::xlen_t                         int_data;
  calc_pkg::xlen_t                         mul_data;

  calc_issue calc_issue_i (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .dispatch_i(dispatch_i),
    .stages_i (chain[`CALC_STAGES:1]),
    .fwd_o    (fwd),
    .entry_o  (chain[0]),
    .hazard_o (hazard_o)
  );

  calc_int_alu calc_int_alu_i (
    .op_i  (fwd.op),
    .rs1_i (fwd.rs1),
    .rs2_i (fwd.rs2),
    .data_o(int_data)
  );

  calc_mul_pipe calc_mul_pipe_i (
    .clk_i  (clk_i),
    .rst_n_i(rst_n_i),
    .fwd_i  (fwd),
    .data_o (mul_data)
  );

  // Completion pipe, every stage sees both unit results
  for (genvar k = 0; k < `CALC_STAGES; k++)
  begin : g_stage
    calc_stage calc_stage_i (
      .clk_i     (clk_i),
      .rst_n_i   (rst_n_i),
      .flush_i   (flush_i),
      .int_data_i(int_data),
      .mul_data_i(mul_data),
      .entry_i   (chain[k]),
      .entry_o   (chain[k+1])
    );
  end

  calc_retire calc_retire_i (
    .clk_i    (clk_i),
    .rst_n_i  (rst_n_i),
    .entry_i  (chain[`CALC_STAGES]),
    .commit_o (commit_o),
    .wb_o     (wb_o),
    .instret_o(instret_o)
  );

endmodule

// File: run_sim.sh
#!/bin/sh
# Compile with Verilator, run, and look for the pass line in the output
verilator --binary --timing --assert -Wno-fatal --top-module tb_calc -f calc.f -o tb_calc \
  && ./obj_dir/tb_calc | tee /dev/stderr | grep -q "SIMULATION PASSED" \
  && echo "run ok" \
  || { echo "run not ok"; exit 1; }

// File: tb_calc.sv
`timescale 1ns/100ps

module tb_calc;

  localparam int CLK_PERIOD = 40;
  localparam int RESET_CYCLES = 5;
  localparam logic [31:0] LFSR_SEED = 32'd38;
  localparam int RAND_ALU_LEN = 40;
  localparam int MUL_MIX_LEN = 40;
  // Idle, directed and drain cycles of all tests together plus a margin
  localparam int TEST_CYCLES = RAND_ALU_LEN + MUL_MIX_LEN + 100;
  localparam int WATCHDOG_NS = (RESET_CYCLES + TEST_CYCLES + 50) * CLK_PERIOD;

  // Expected retirement of one dispatched instruction
  typedef struct packed {
    logic                v;
    logic                killed;
    calc_pkg::pc_t       pc;
    logic                wb_v;
    calc_pkg::reg_addr_t rd;
    calc_pkg::xlen_t     data;
  } exp_rec_s;

  logic                clk;
  logic                rst_n;
  logic                flush;
  calc_pkg::dispatch_s dispatch;
  logic                hazard;
  calc_pkg::commit_s   commit;
  calc_pkg::wb_s       wb;
  calc_pkg::instret_t  instret;

  logic [31:0]        lfsr_state;
  calc_pkg::xlen_t    arch_rf [32];
  calc_pkg::xlen_t    spec_rf [32];
  int                 last_wr [32];
  int                 last_mul [32];
  int                 cyc;
  calc_pkg::pc_t      pc_ctr;
  exp_rec_s           drv_rec;
  exp_rec_s           exp_pipe [4];
  logic               exp_hazard;
  calc_pkg::instret_t exp_instret;
  int                 commits_seen;
  int                 err_cnt;
  int                 tests_passed;
  int                 tests_failed;

  logic exp_commit_v;
  logic exp_wb_v;

  calc_top calc_top_i (
    .clk_i     (clk),
    .rst_n_i   (rst_n),
    .dispatch_i(dispatch),
    .flush_i   (flush),
    .hazard_o  (hazard),
    .commit_o  (commit),
    .wb_o      (wb),
    .instret_o (instret)
  );

  initial
  begin
    clk = 1'b0;
    forever
      #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial
  begin
    #(WATCHDOG_NS);
    $display("Watchdog expired, the tests did not finish in time");
    $display("SIMULATION FAILED");
    $finish;
  end

  // Galois LFSR stepped once per random bit
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] value;
    logic        lsb;
    value = '0;
    for (int i = 0; i < n; i++)
    begin
      lsb = lfsr_state[0];
      lfsr_state = lfsr_state >> 1;
      if (lsb)
        lfsr_state = lfsr_state ^ 32'h8020_0003;
      value = {value[30:0], lsb};
    end
    return value;
  endfunction

  function automatic calc_pkg::xlen_t model_op(input calc_pkg::fu_op_e op,
                                               input calc_pkg::xlen_t a,
                                               input calc_pkg::xlen_t b);
    logic [63:0] prod;
    prod = {32'd0, a} * {32'd0, b};
    case (op)
      calc_pkg::e_op_add:   return a + b;
      calc_pkg::e_op_sub:   return a - b;
      calc_pkg::e_op_and:   return a & b;
      calc_pkg::e_op_or:    return a | b;
      calc_pkg::e_op_xor:   return a ^ b;
      calc_pkg::e_op_sll:   return a << b[4:0];
      calc_pkg::e_op_srl:   return a >> b[4:0];
      calc_pkg::e_op_slt:   return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      calc_pkg::e_op_mul:   return prod[31:0];
      calc_pkg::e_op_mulhu: return prod[63:32];
      default:              return '0;
    endcase
  endfunction

  // A multiply result is missing for two cycles after its dispatch
  function automatic logic src_pending(input calc_pkg::reg_addr_t r, input int d);
    return (r != '0) && ((d - last_mul[r]) <= 2);
  endfunction

  function automatic calc_pkg::reg_addr_t safe_src(input calc_pkg::reg_addr_t r);
    return src_pending(r, cyc + 1) ? calc_pkg::reg_addr_t'(0) : r;
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic idle(input int n);
    for (int i = 0; i < n; i++)
    begin
      dispatch.v = 1'b0;
      drv_rec = '0;
      exp_hazard = 1'b0;
      next_cycle();
    end
  endtask

  // Drives one instruction and gives sources still in flight a wrong value
  task automatic send(input calc_pkg::fu_op_e op, input calc_pkg::reg_addr_t rd,
                      input calc_pkg::reg_addr_t rs1a, input calc_pkg::reg_addr_t rs2a,
                      input logic wr);
    int              d;
    calc_pkg::xlen_t a;
    calc_pkg::xlen_t b;
    calc_pkg::xlen_t res;
    logic            is_mul;
    d = cyc + 1;
    a = spec_rf[rs1a];
    b = spec_rf[rs2a];
    res = model_op(op, a, b);
    is_mul = (op == calc_pkg::e_op_mul) || (op == calc_pkg::e_op_mulhu);
    exp_hazard = src_pending(rs1a, d) || src_pending(rs2a, d);
    dispatch.v = 1'b1;
    dispatch.pc = pc_ctr;
    dispatch.op = op;
    dispatch.rd_w_v = wr;
    dispatch.rd_addr = rd;
    dispatch.rs1_addr = rs1a;
    dispatch.rs2_addr = rs2a;
    dispatch.rs1 = ((d - last_wr[rs1a]) <= 4) ? ~arch_rf[rs1a] : arch_rf[rs1a];
    dispatch.rs2 = ((d - last_wr[rs2a]) <= 4) ? ~arch_rf[rs2a] : arch_rf[rs2a];
    drv_rec.v = 1'b1;
    drv_rec.killed = 1'b0;
    drv_rec.pc = pc_ctr;
    drv_rec.wb_v = wr && (rd != '0);
    drv_rec.rd = rd;
    drv_rec.data = res;
    if (wr && (rd != '0))
    begin
      spec_rf[rd] = res;
      last_wr[rd] = d;
      if (is_mul)
        last_mul[rd] = d;
    end
    pc_ctr = pc_ctr + 32'd4;
    next_cycle();
  endtask

  // Instruction with no destination for looking at hazard_o
  task automatic probe(input calc_pkg::reg_addr_t rs1a, input calc_pkg::reg_addr_t rs2a);
    send(calc_pkg::e_op_add, '0, rs1a, rs2a, 1'b0);
  endtask

  task automatic resync();
    for (int i = 0; i < 32; i++)
    begin
      spec_rf[i] = arch_rf[i];
      last_wr[i] = -100;
      last_mul[i] = -100;
    end
  endtask

  task automatic end_test(input string name, input int errs_before);
    if (err_cnt == errs_before)
    begin
      tests_passed++;
      $display("test %s: passed", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, err_cnt - errs_before);
    end
  endtask

  // Shadow of the fixed four-cycle retirement where flush kills what is in flight
  always @(posedge clk)
  begin
    cyc = cyc + 1;
    if (!rst_n)
    begin
      for (int k = 0; k < 4; k++)
        exp_pipe[k] <= '0;
      exp_instret <= '0;
      commits_seen <= 0;
    end
    else
    begin
      exp_pipe[0] <= drv_rec;
      exp_pipe[0].killed <= drv_rec.killed | flush;
      for (int k = 1; k < 4; k++)
      begin
        exp_pipe[k] <= exp_pipe[k-1];
        exp_pipe[k].killed <= exp_pipe[k-1].killed | flush;
      end
      if (exp_commit_v)
        exp_instret <= exp_instret + 16'd1;
      if (exp_wb_v)
        arch_rf[exp_pipe[3].rd] = exp_pipe[3].data;
      if (commit.v)
        commits_seen <= commits_seen + 1;
    end
  end

  assign exp_commit_v = exp_pipe[3].v && !exp_pipe[3].killed;
  assign exp_wb_v = exp_commit_v && exp_pipe[3].wb_v;

  a_commit_v: assert property (@(posedge clk) disable iff (!rst_n) commit.v == exp_commit_v)
    else
    begin
      $display("FAILED commit_o.v exp %h got %h", $sampled(exp_commit_v), $sampled(commit.v));
      err_cnt++;
    end

  a_commit_pc: assert property (@(posedge clk) disable iff (!rst_n)
                                exp_commit_v |-> commit.pc == exp_pipe[3].pc)
    else
    begin
      $display("FAILED commit_o.pc exp %h got %h", $sampled(exp_pipe[3].pc), $sampled(commit.pc));
      err_cnt++;
    end

  a_wb_v: assert property (@(posedge clk) disable iff (!rst_n) wb.v == exp_wb_v)
    else
    begin
      $display("FAILED wb_o.v exp %h got %h", $sampled(exp_wb_v), $sampled(wb.v));
      err_cnt++;
    end

  a_wb_data: assert property (@(posedge clk) disable iff (!rst_n)
                              exp_wb_v |-> (wb.rd_addr == exp_pipe[3].rd
                                            && wb.data == exp_pipe[3].data))
    else
    begin
      $display("FAILED wb_o exp rd %h data %h got rd %h data %h",
               $sampled(exp_pipe[3].rd), $sampled(exp_pipe[3].data),
               $sampled(wb.rd_addr), $sampled(wb.data));
      err_cnt++;
    end

  a_hazard: assert property (@(posedge clk) disable iff (!rst_n) hazard == exp_hazard)
    else
    begin
      $display("FAILED hazard_o exp %h got %h", $sampled(exp_hazard), $sampled(hazard));
      err_cnt++;
    end

  a_instret: assert property (@(posedge clk) disable iff (!rst_n) instret == exp_instret)
    else
    begin
      $display("FAILED instret_o exp %h got %h", $sampled(exp_instret), $sampled(instret));
      err_cnt++;
    end

  initial
  begin
    int                  errs;
    logic                pick_mul;
    calc_pkg::fu_op_e    op;
    calc_pkg::reg_addr_t rd;
    lfsr_state = LFSR_SEED;
    err_cnt = 0;
    tests_passed = 0;
    tests_failed = 0;
    cyc = 0;
    pc_ctr = 32'h0000_1000;
    rst_n = 1'b0;
    flush = 1'b0;
    dispatch = '0;
    drv_rec = '0;
    exp_hazard = 1'b0;
    arch_rf[0] = '0;
    for (int i = 1; i < 32; i++)
      arch_rf[i] = rand_bits(32);
    resync();
    repeat (RESET_CYCLES) @(posedge clk);
    #2;
    rst_n = 1'b1;
    next_cycle();

    errs = err_cnt;
    for (int i = 0; i < RAND_ALU_LEN; i++)
    begin
      op = calc_pkg::fu_op_e'(rand_bits(3));
      rd = (i % 8 == 3) ? calc_pkg::reg_addr_t'(0) : calc_pkg::reg_addr_t'(rand_bits(5));
      send(op, rd, rand_bits(5), rand_bits(5), 1'b1);
    end
    idle(6);
    end_test("random_alu", errs);

    errs = err_cnt;
    for (int i = 0; i < MUL_MIX_LEN; i++)
    begin
      pick_mul = rand_bits(1);
      if (pick_mul)
        op = rand_bits(1) ? calc_pkg::e_op_mulhu : calc_pkg::e_op_mul;
      else
        op = calc_pkg::fu_op_e'(rand_bits(3));
      rd = calc_pkg::reg_addr_t'(rand_bits(5));
      send(op, rd, safe_src(rand_bits(5)), safe_src(rand_bits(5)), 1'b1);
    end
    idle(6);
    end_test("mul_mix", errs);

    // Producers in stage 0, in stage 2 after a multiply, and at retire
    errs = err_cnt;
    send(calc_pkg::e_op_add, 5'd5, 5'd1, 5'd2, 1'b1);
    send(calc_pkg::e_op_add, 5'd6, 5'd5, 5'd5, 1'b1);
    send(calc_pkg::e_op_sub, 5'd7, 5'd5, 5'd6, 1'b1);
    send(calc_pkg::e_op_mul, 5'd8, 5'd5, 5'd6, 1'b1);
    idle(2);
    send(calc_pkg::e_op_add, 5'd9, 5'd8, 5'd1, 1'b1);
    send(calc_pkg::e_op_sub, 5'd10, 5'd8, 5'd7, 1'b1);
    idle(1);
    send(calc_pkg::e_op_xor, 5'd11, 5'd10, 5'd9, 1'b1);
    idle(6);
    end_test("bypass", errs);

    errs = err_cnt;
    send(calc_pkg::e_op_mulhu, 5'd12, 5'd3, 5'd4, 1'b1);
    probe(5'd12, 5'd1);
    probe(5'd2, 5'd12);
    send(calc_pkg::e_op_add, 5'd13, 5'd12, 5'd1, 1'b1);
    send(calc_pkg::e_op_mul, 5'd0, 5'd3, 5'd4, 1'b1);
    probe(5'd0, 5'd0);
    probe(5'd14, 5'd15);
    send(calc_pkg::e_op_add, 5'd14, 5'd1, 5'd2, 1'b1);
    probe(5'd14, 5'd14);
    idle(6);
    end_test("hazard", errs);

    // Four in the stages and the fifth dispatched with the flush
    errs = err_cnt;
    for (int i = 0; i < 5; i++)
    begin
      if (i == 4)
        flush = 1'b1;
      op = rand_bits(1) ? calc_pkg::e_op_mul : calc_pkg::e_op_or;
      send(op, calc_pkg::reg_addr_t'(16 + i), 5'd1, 5'd2, 1'b1);
    end
    flush = 1'b0;
    idle(6);
    resync();
    send(calc_pkg::e_op_add, 5'd20, 5'd16, 5'd17, 1'b1);
    idle(6);
    a_instret_commits: assert (instret == calc_pkg::instret_t'(commits_seen))
      else
      begin
        $display("FAILED instret_o exp %h got %h", calc_pkg::instret_t'(commits_seen), instret);
        err_cnt++;
      end
    end_test("flush", errs);

    $display("tests passed %0d failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && err_cnt == 0)
    begin
      $display("SIMULATION PASSED");
    end
    else
    begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule
